//--- mips_pkg.sv
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;       // Data word or byte address
    typedef logic [4:0]  reg_addr_t;
    typedef logic [15:0] imm16_t;
    typedef logic [25:0] target26_t;   // J-type word index

    typedef enum logic [1:0] {
        FETCH,
        EXEC1,
        EXEC2
    } phase_t;

    // One strobe per supported control-flow instruction
    typedef struct packed {
        logic j;
        logic jal;
        logic jr;
        logic jalr;
        logic beq;
        logic bne;
        logic bgez;
        logic bgezal;
        logic bgtz;
        logic blez;
        logic bltz;
        logic bltzal;
    } branch_ctrl_t;

    // Primary opcodes, instr[31:26]
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_REGIMM  = 6'h01;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_BLEZ    = 6'h06;
    localparam logic [5:0] OP_BGTZ    = 6'h07;

    localparam logic [5:0] FN_JR   = 6'h08;   // SPECIAL funct
    localparam logic [5:0] FN_JALR = 6'h09;

    // REGIMM selects the branch through the rt field
    localparam reg_addr_t RT_BLTZ   = 5'h00;
    localparam reg_addr_t RT_BGEZ   = 5'h01;
    localparam reg_addr_t RT_BLTZAL = 5'h10;
    localparam reg_addr_t RT_BGEZAL = 5'h11;

    localparam reg_addr_t LINK_REG = 5'd31;
    localparam word_t     RESET_PC = 32'h0000_0000;

endpackage

`default_nettype wire

//--- branch_decoder.sv
`default_nettype none

module branch_decoder
    import mips_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,
    input  logic         stall,
    input  phase_t       phase,
    input  word_t        instr,
    output branch_ctrl_t ctrl,
    output reg_addr_t    rs_addr,
    output reg_addr_t    rt_addr,
    output reg_addr_t    rd_addr,
    output imm16_t       imm,
    output target26_t    target
);

    word_t     ir;
    logic [5:0] opcode;
    logic [5:0] funct;

    // Zero after reset decodes as a plain instruction
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ir <= '0;
        end else if (phase == FETCH && !stall) begin
            ir <= instr;
        end
    end

    assign opcode  = ir[31:26];
    assign funct   = ir[5:0];
    assign rs_addr = ir[25:21];
    assign rt_addr = ir[20:16];
    assign rd_addr = ir[15:11];
    assign imm     = ir[15:0];
    assign target  = ir[25:0];

    always_comb begin
        ctrl = '0;
        case (opcode)
            OP_SPECIAL: begin
                if (funct == FN_JR) begin
                    ctrl.jr = 1'b1;
                end else if (funct == FN_JALR) begin
                    ctrl.jalr = 1'b1;
                end
            end
            OP_REGIMM: begin
                case (rt_addr)
                    RT_BLTZ:   ctrl.bltz   = 1'b1;
                    RT_BGEZ:   ctrl.bgez   = 1'b1;
                    RT_BLTZAL: ctrl.bltzal = 1'b1;
                    RT_BGEZAL: ctrl.bgezal = 1'b1;
                    default:   ;             // Other REGIMM forms are plain
                endcase
            end
            OP_J:    ctrl.j    = 1'b1;
            OP_JAL:  ctrl.jal  = 1'b1;
            OP_BEQ:  ctrl.beq  = 1'b1;
            OP_BNE:  ctrl.bne  = 1'b1;
            OP_BLEZ: ctrl.blez = 1'b1;
            OP_BGTZ: ctrl.bgtz = 1'b1;
            default: ;
        endcase
    end

    // Next-PC selection relies on at most one strobe per instruction
    a_ctrl_onehot0 : assert property (
        @(posedge clk) disable iff (!arst_n)
        $onehot0(ctrl)
    );

endmodule

`default_nettype wire

//--- reg_file.sv
`default_nettype none

module reg_file
    import mips_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      stall,
    input  phase_t    phase,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    output word_t     rs_val,
    output word_t     rt_val,
    input  logic      link_we,
    input  reg_addr_t link_addr,
    input  word_t     link_data,
    input  logic      pre_we,
    input  reg_addr_t pre_addr,
    input  word_t     pre_data
);

    word_t regs [32];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            regs   <= '{default: '0};
            rs_val <= '0;
            rt_val <= '0;
        end else begin
            // Link write beats a preload to the same edge
            if (link_we) begin
                if (link_addr != '0) begin
                    regs[link_addr] <= link_data;
                end
            end else if (pre_we && pre_addr != '0) begin
                regs[pre_addr] <= pre_data;
            end

            if (phase == EXEC1 && !stall) begin   // Operand capture
                rs_val <= regs[rs_addr];
                rt_val <= regs[rt_addr];
            end
        end
    end

    // r0 stays zero even after a JALR with rd = 0
    a_r0_reads_zero : assert property (
        @(posedge clk) disable iff (!arst_n)
        (phase == EXEC1 && !stall && (rs_addr == '0 || rt_addr == '0))
        |=> ((rs_addr != '0 || rs_val == '0) && (rt_addr != '0 || rt_val == '0))
    );

endmodule

`default_nettype wire

//--- next_pc_unit.sv
`default_nettype none

module next_pc_unit
    import mips_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,
    input  logic         stall,
    input  branch_ctrl_t ctrl,
    input  word_t        rs_val,
    input  word_t        rt_val,
    input  imm16_t       imm,
    input  target26_t    target,
    input  reg_addr_t    rd_addr,
    output word_t        pc,
    output phase_t       phase,
    output logic         link_we,
    output reg_addr_t    link_addr,
    output word_t        link_data
);

    word_t              pc_plus4;
    word_t              branch_off;
    word_t              next_pc;
    logic signed [31:0] rs_s;
    logic               taken;
    logic               link;

    assign pc_plus4   = pc + 32'd4;
    assign branch_off = {{14{imm[15]}}, imm, 2'b00};   // Sign-extended word offset
    assign rs_s       = rs_val;

    always_comb begin
        taken = 1'b0;
        if (ctrl.beq && rs_val == rt_val) begin
            taken = 1'b1;
        end
        if (ctrl.bne && rs_val != rt_val) begin
            taken = 1'b1;
        end
        if ((ctrl.bgez || ctrl.bgezal) && rs_s >= 0) begin
            taken = 1'b1;
        end
        if (ctrl.bgtz && rs_s > 0) begin
            taken = 1'b1;
        end
        if (ctrl.blez && rs_s <= 0) begin
            taken = 1'b1;
        end
        if ((ctrl.bltz || ctrl.bltzal) && rs_s < 0) begin
            taken = 1'b1;
        end
    end

    always_comb begin
        if (ctrl.jr || ctrl.jalr) begin
            next_pc = {rs_val[31:2], 2'b00};   // No address exceptions here
        end else if (ctrl.j || ctrl.jal) begin
            next_pc = {pc_plus4[31:28], target, 2'b00};   // Stays in the 256 MB region
        end else if (taken) begin
            next_pc = pc_plus4 + branch_off;
        end else begin
            next_pc = pc_plus4;
        end
    end

    // The AL branches link even when not taken
    assign link = ctrl.jal || ctrl.jalr || ctrl.bgezal || ctrl.bltzal;

    assign link_we   = link && phase == EXEC2 && !stall;
    assign link_addr = ctrl.jalr ? rd_addr : LINK_REG;
    assign link_data = pc_plus4;

    // Three-phase sequencer with the PC update at the end of EXEC2
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase <= FETCH;
            pc    <= RESET_PC;
        end else if (!stall) begin
            case (phase)
                FETCH: phase <= EXEC1;
                EXEC1: phase <= EXEC2;
                EXEC2: begin
                    phase <= FETCH;
                    pc    <= next_pc;
                end
                default: phase <= FETCH;
            endcase
        end
    end

    a_pc_aligned : assert property (
        @(posedge clk) disable iff (!arst_n)
        pc[1:0] == 2'b00
    );

    // Link write only in an unstalled EXEC2, so the next cycle is a fetch
    a_link_in_exec2 : assert property (
        @(posedge clk) disable iff (!arst_n)
        link_we |-> (phase == EXEC2) ##1 (phase == FETCH)
    );

endmodule

`default_nettype wire

//--- control_flow_top.sv
`default_nettype none

module control_flow_top
    import mips_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      stall,
    input  word_t     instr,
    input  logic      pre_we,
    input  reg_addr_t pre_addr,
    input  word_t     pre_data,
    output word_t     pc,
    output phase_t    phase,
    output logic      link_we,
    output reg_addr_t link_addr,
    output word_t     link_data
);

    branch_ctrl_t ctrl;
    reg_addr_t    rs_addr;
    reg_addr_t    rt_addr;
    reg_addr_t    rd_addr;
    imm16_t       imm;
    target26_t    target;
    word_t        rs_val;
    word_t        rt_val;

    branch_decoder branch_decoder_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .stall   (stall),
        .phase   (phase),
        .instr   (instr),
        .ctrl    (ctrl),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .rd_addr (rd_addr),
        .imm     (imm),
        .target  (target)
    );

    reg_file reg_file_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .stall     (stall),
        .phase     (phase),
        .rs_addr   (rs_addr),
        .rt_addr   (rt_addr),
        .rs_val    (rs_val),
        .rt_val    (rt_val),
        .link_we   (link_we),     // Link writes go back into the file
        .link_addr (link_addr),
        .link_data (link_data),
        .pre_we    (pre_we),
        .pre_addr  (pre_addr),
        .pre_data  (pre_data)
    );

    next_pc_unit next_pc_unit_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .stall     (stall),
        .ctrl      (ctrl),
        .rs_val    (rs_val),
        .rt_val    (rt_val),
        .imm       (imm),
        .target    (target),
        .rd_addr   (rd_addr),
        .pc        (pc),
        .phase     (phase),
        .link_we   (link_we),
        .link_addr (link_addr),
        .link_data (link_data)
    );

endmodule

`default_nettype wire

//--- tb_control_flow.sv
`default_nettype none

module tb_control_flow
    import mips_pkg::*;
;

    localparam int NUM_RANDOM   = 400;
    localparam int NUM_DIRECTED = 4;
    localparam int NUM_INSTR    = NUM_RANDOM + NUM_DIRECTED;
    localparam int MAX_CYCLES   = NUM_INSTR * 3 * 2 + 200;

    logic      clk;
    logic      arst_n;
    logic      stall;
    word_t     instr;
    logic      pre_we;
    reg_addr_t pre_addr;
    word_t     pre_data;
    word_t     pc;
    phase_t    phase;
    logic      link_we;
    reg_addr_t link_addr;
    word_t     link_data;

    // Reference state
    word_t  m_regs [32];
    word_t  m_pc;
    word_t  m_ir;
    phase_t m_phase;
    word_t  directed [NUM_DIRECTED];

    integer seed = 32'hd523_277b;
    int     errors = 0;
    int     checks = 0;
    int     done = 0;
    int     issued = 0;
    int     cycles = 0;

    control_flow_top control_flow_top_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .stall     (stall),
        .instr     (instr),
        .pre_we    (pre_we),
        .pre_addr  (pre_addr),
        .pre_data  (pre_data),
        .pc        (pc),
        .phase     (phase),
        .link_we   (link_we),
        .link_addr (link_addr),
        .link_data (link_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic compare_word(input string name, input word_t exp, input word_t act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // Random word biased toward the twelve control-flow forms
    task automatic make_instr(output word_t w);
        int        sel;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        sel = $unsigned($random(seed)) % 16;
        w   = $random(seed);
        rs  = w[25:21];
        rt  = w[20:16];
        rd  = w[15:11];
        if (($random(seed) & 3) == 0) begin
            rt = rs;                          // Forces equal operands now and then
        end
        case (sel)
            0:  w = {OP_J, w[25:0]};
            1:  w = {OP_JAL, w[25:0]};
            2:  w = {OP_SPECIAL, rs, 5'd0, 5'd0, 5'd0, FN_JR};
            3:  w = {OP_SPECIAL, rs, 5'd0, rd, 5'd0, FN_JALR};
            4:  w = {OP_BEQ, rs, rt, w[15:0]};
            5:  w = {OP_BNE, rs, rt, w[15:0]};
            6:  w = {OP_REGIMM, rs, RT_BGEZ, w[15:0]};
            7:  w = {OP_REGIMM, rs, RT_BGEZAL, w[15:0]};
            8:  w = {OP_BGTZ, rs, 5'd0, w[15:0]};
            9:  w = {OP_BLEZ, rs, 5'd0, w[15:0]};
            10: w = {OP_REGIMM, rs, RT_BLTZ, w[15:0]};
            11: w = {OP_REGIMM, rs, RT_BLTZAL, w[15:0]};
            default: ;                        // Plain word, PC+4
        endcase
    endtask

    // Expected outcome of the instruction in m_ir at the current m_pc
    task automatic model_exec(output word_t npc, output logic lnk, output reg_addr_t laddr);
        word_t seq;
        word_t a;
        word_t b;
        word_t off;
        logic  take;
        seq   = m_pc + 32'd4;
        a     = m_regs[m_ir[25:21]];
        b     = m_regs[m_ir[20:16]];
        off   = $signed(m_ir[15:0]) * 4;
        npc   = seq;
        take  = 1'b0;
        lnk   = 1'b0;
        laddr = LINK_REG;
        case (m_ir[31:26])
            OP_J, OP_JAL: begin
                npc = {seq[31:28], m_ir[25:0], 2'b00};   // Region of PC+4
                lnk = (m_ir[31:26] == OP_JAL);
            end
            OP_SPECIAL: begin
                if (m_ir[5:0] == FN_JR || m_ir[5:0] == FN_JALR) begin
                    npc = a & ~32'd3;
                end
                if (m_ir[5:0] == FN_JALR) begin
                    lnk   = 1'b1;
                    laddr = m_ir[15:11];
                end
            end
            OP_REGIMM: begin
                case (m_ir[20:16])
                    RT_BLTZ:   take = $signed(a) < 0;
                    RT_BGEZ:   take = $signed(a) >= 0;
                    RT_BLTZAL: begin
                        take = $signed(a) < 0;
                        lnk  = 1'b1;
                    end
                    RT_BGEZAL: begin
                        take = $signed(a) >= 0;
                        lnk  = 1'b1;
                    end
                    default: ;
                endcase
            end
            OP_BEQ:  take = (a == b);
            OP_BNE:  take = (a != b);
            OP_BLEZ: take = $signed(a) <= 0;
            OP_BGTZ: take = $signed(a) > 0;
            default: ;
        endcase
        if (take) begin
            npc = seq + off;
        end
    endtask

    initial begin
        word_t     exp_pc;
        logic      exp_lnk;
        reg_addr_t exp_laddr;
        word_t     data;
        logic      need_new;
        arst_n   = 1'b0;
        stall    = 1'b0;
        instr    = '0;
        pre_we   = 1'b0;
        pre_addr = '0;
        pre_data = '0;
        m_regs   = '{default: '0};
        m_pc     = RESET_PC;
        m_ir     = '0;
        m_phase  = FETCH;
        need_new = 1'b1;

        // JALR into r0, JR through r0, then JAL and a return through r31
        directed[0] = {OP_SPECIAL, 5'd5, 5'd0, 5'd0, 5'd0, FN_JALR};
        directed[1] = {OP_SPECIAL, 5'd0, 5'd0, 5'd0, 5'd0, FN_JR};
        directed[2] = {OP_JAL, 26'h012_3456};
        directed[3] = {OP_SPECIAL, 5'd31, 5'd0, 5'd0, 5'd0, FN_JR};

        repeat (8) @(negedge clk);
        compare_word("reset pc", RESET_PC, pc);
        compare_word("reset phase", {30'd0, FETCH}, {30'd0, phase});
        compare_word("reset link_we", 32'd0, {31'd0, link_we});
        arst_n = 1'b1;

        // Preload under stall so no link write can collide
        stall = 1'b1;
        for (int i = 1; i < 32; i++) begin
            data = $random(seed);
            data[31] = ($unsigned($random(seed)) % 10) < 3;   // About 30% negative
            pre_we   = 1'b1;
            pre_addr = reg_addr_t'(i);
            pre_data = data;
            m_regs[i] = data;
            @(negedge clk);
        end
        pre_we = 1'b0;

        while (done < NUM_INSTR) begin
            compare_word("pc", m_pc, pc);
            compare_word("phase", {30'd0, m_phase}, {30'd0, phase});
            stall = ($random(seed) & 7) == 0;
            if (m_phase == FETCH && need_new) begin
                if (issued < NUM_RANDOM) begin
                    make_instr(instr);
                end else begin
                    instr = directed[issued - NUM_RANDOM];
                end
                issued++;
                need_new = 1'b0;
            end
            #1;
            if (m_phase == EXEC2 && !stall) begin
                model_exec(exp_pc, exp_lnk, exp_laddr);
                compare_word("link_we", {31'd0, exp_lnk}, {31'd0, link_we});
                if (exp_lnk) begin
                    compare_word("link_addr", {27'd0, exp_laddr}, {27'd0, link_addr});
                    compare_word("link_data", m_pc + 32'd4, link_data);
                    if (exp_laddr != '0) begin
                        m_regs[exp_laddr] = m_pc + 32'd4;
                    end
                end
                m_pc = exp_pc;
                m_phase = FETCH;
                need_new = 1'b1;
                done++;
            end else begin
                compare_word("link_we idle", 32'd0, {31'd0, link_we});
                if (!stall) begin
                    if (m_phase == FETCH) begin
                        m_ir = instr;
                        m_phase = EXEC1;
                    end else begin
                        m_phase = EXEC2;
                    end
                end
            end
            @(negedge clk);
        end
        compare_word("final pc", m_pc, pc);
        compare_word("final phase", {30'd0, m_phase}, {30'd0, phase});

        $display("Instructions: %0d, checks: %0d, errors: %0d", done, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Limit from the instruction count, with stalls and preload margin
    initial begin
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: no end after %0d cycles, %0d of %0d instructions done",
                 cycles, done, NUM_INSTR);
        $display("Instructions: %0d, checks: %0d, errors: %0d", done, checks, errors + 1);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
mips_pkg.sv
branch_decoder.sv
reg_file.sv
next_pc_unit.sv
control_flow_top.sv
tb_control_flow.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and decide from the simulation log
verilator --binary --timing --assert -Wno-fatal --top-module tb_control_flow \
    -f vlog.f -o sim_control_flow > build.log 2>&1 &&
./obj_dir/sim_control_flow > sim.log 2>&1
cat sim.log
grep -q "ALL TESTS PASSED" sim.log && echo "run.sh: pass" || {
    echo "run.sh: fail, see build.log and sim.log"
    exit 1
}
